// ==== project.f ====
rtl/rcc_pkg.sv
rtl/rcc_axil_slave.sv
rtl/rcc_vdd_regs.sv
rtl/rcc_rst_flags.sv
rtl/rcc_vdd_top.sv
verif/tb_rcc_vdd.sv

// ==== rtl/rcc_axil_slave.sv ====
`timescale 1ns/1ps
`default_nettype none

module rcc_axil_slave (
    input  logic               clk,
    input  logic               rst,
    input  rcc_pkg::axil_req_t bus_req,
    output rcc_pkg::axil_rsp_t bus_rsp,
    output rcc_pkg::reg_wr_t   reg_wr,
    output rcc_pkg::reg_sel_e  rd_sel,
    input  logic [31:0]        rd_data
);
    import rcc_pkg::*;

    reg_sel_e    wr_sel;
    logic        wr_acc;
    logic        rd_acc;
    logic        bvalid_q;
    logic [1:0]  bresp_q;
    logic        rvalid_q;
    logic [31:0] rdata_q;
    logic [1:0]  rresp_q;

    // the only address decoder, shared by both channels
    function automatic reg_sel_e decode(input logic [AXI_ADDR_W-1:0] addr);
        reg_sel_e sel;
        case (addr)
            CSR_ADDR:    sel = REG_CSR;
            C1_RSR_ADDR: sel = REG_C1_RSR;
            C2_RSR_ADDR: sel = REG_C2_RSR;
            default:     sel = REG_NONE;
        endcase
        return sel;
    endfunction

    // ------------------------------------------------------------------------
    // write channel
    // ------------------------------------------------------------------------
    assign wr_sel = decode(bus_req.awaddr);
    // address and data together, blocked while a response waits
    assign wr_acc = bus_req.awvalid && bus_req.wvalid && !bvalid_q;

    // unmapped writes never reach the register block
    always_comb begin
        reg_wr.valid = wr_acc && (wr_sel != REG_NONE);
        reg_wr.sel   = wr_sel;
        reg_wr.data  = bus_req.wdata;
        reg_wr.strb  = bus_req.wstrb;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid_q <= 1'b0;
        end else if (wr_acc) begin
            bvalid_q <= 1'b1;
        end else if (bus_req.bready) begin
            bvalid_q <= 1'b0;
        end
    end

    // response code captured with the accept
    always_ff @(posedge clk) begin
        if (wr_acc) begin
            bresp_q <= (wr_sel == REG_NONE) ? RESP_SLVERR : RESP_OKAY;
        end
    end

    // ------------------------------------------------------------------------
    // read channel
    // ------------------------------------------------------------------------
    assign rd_sel = decode(bus_req.araddr);
    assign rd_acc = bus_req.arvalid && !rvalid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid_q <= 1'b0;
        end else if (rd_acc) begin
            rvalid_q <= 1'b1;
        end else if (bus_req.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    // rd_data is already zero for an unmapped offset
    always_ff @(posedge clk) begin
        if (rd_acc) begin
            rdata_q <= rd_data;
            rresp_q <= (rd_sel == REG_NONE) ? RESP_SLVERR : RESP_OKAY;
        end
    end

    // response bundle
    always_comb begin
        bus_rsp.awready = wr_acc;
        bus_rsp.wready  = wr_acc;
        bus_rsp.bvalid  = bvalid_q;
        bus_rsp.bresp   = bresp_q;
        bus_rsp.arready = rd_acc;
        bus_rsp.rvalid  = rvalid_q;
        bus_rsp.rdata   = rdata_q;
        bus_rsp.rresp   = rresp_q;
    end

    // pending responses hold, unchanged, until taken
    a_bvalid_hold : assert property (@(posedge clk) disable iff (rst)
        bus_rsp.bvalid && !bus_req.bready |=> bus_rsp.bvalid && $stable(bus_rsp.bresp));

    a_rvalid_hold : assert property (@(posedge clk) disable iff (rst)
        bus_rsp.rvalid && !bus_req.rready |=>
            bus_rsp.rvalid && $stable(bus_rsp.rdata) && $stable(bus_rsp.rresp));

endmodule

`default_nettype wire

// ==== rtl/rcc_pkg.sv ====
`default_nettype none

package rcc_pkg;

    // ------------------------------------------------------------------------
    // bus geometry and register map
    // ------------------------------------------------------------------------
    localparam int AXI_ADDR_W = 12;
    localparam int AXI_DATA_W = 32;

    // byte offsets inside the rcc block
    localparam logic [AXI_ADDR_W-1:0] CSR_ADDR    = 12'h074;
    localparam logic [AXI_ADDR_W-1:0] C1_RSR_ADDR = 12'h130;
    localparam logic [AXI_ADDR_W-1:0] C2_RSR_ADDR = 12'h190;

    // bit positions of the writable and live bits
    localparam int RMVF_BIT   = 16;
    localparam int LSION_BIT  = 0;
    localparam int LSIRDY_BIT = 1;

    // axi response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // decoded target of an access
    typedef enum logic [1:0] {
        REG_NONE,
        REG_CSR,
        REG_C1_RSR,
        REG_C2_RSR
    } reg_sel_e;

    // ------------------------------------------------------------------------
    // reset-cause flags
    // ------------------------------------------------------------------------
    // msb first, bits 31..19 of the status word, obl sits apart at 17
    typedef struct packed {
        logic lpwr2;
        logic lpwr1;
        logic wwdg2;
        logic wwdg1;
        logic iwdg2;
        logic iwdg1;
        logic sft2;
        logic sft1;
        logic por;
        logic pin;
        logic bor;
        logic d2;
        logic d1;
        logic obl;
    } rst_evt_t;

    // status word as laid out on the bus
    typedef struct packed {
        // lpwr2 down to d1
        logic [12:0] evt_hi;
        logic        rsvd18;
        logic        obl;
        logic        rmvf;
        logic [15:0] rsvd_lo;
    } rsr_fields_t;

    // same word, either raw bus data or decoded fields
    typedef union packed {
        logic [AXI_DATA_W-1:0] raw;
        rsr_fields_t           fields;
    } rsr_word_u;

    // power-up causes come up set
    localparam rst_evt_t RSR_RESET_VAL = '{
        lpwr2: 1'b0, lpwr1: 1'b0, wwdg2: 1'b0, wwdg1: 1'b0,
        iwdg2: 1'b0, iwdg1: 1'b0, sft2: 1'b0,  sft1: 1'b0,
        por: 1'b1,   pin: 1'b1,   bor: 1'b1,   d2: 1'b1,
        d1: 1'b1,    obl: 1'b0
    };

    // ------------------------------------------------------------------------
    // bus and internal transfer structs
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic                    awvalid;
        logic [AXI_ADDR_W-1:0]   awaddr;
        logic                    wvalid;
        logic [AXI_DATA_W-1:0]   wdata;
        logic [AXI_DATA_W/8-1:0] wstrb;
        logic                    bready;
        logic                    arvalid;
        logic [AXI_ADDR_W-1:0]   araddr;
        logic                    rready;
    } axil_req_t;

    typedef struct packed {
        logic                  awready;
        logic                  wready;
        logic                  bvalid;
        logic [1:0]            bresp;
        logic                  arready;
        logic                  rvalid;
        logic [AXI_DATA_W-1:0] rdata;
        logic [1:0]            rresp;
    } axil_rsp_t;

    // one accepted write, already decoded
    typedef struct packed {
        logic                    valid;
        reg_sel_e                sel;
        logic [AXI_DATA_W-1:0]   data;
        logic [AXI_DATA_W/8-1:0] strb;
    } reg_wr_t;

endpackage

`default_nettype wire

// ==== rtl/rcc_rst_flags.sv ====
`timescale 1ns/1ps
`default_nettype none

module rcc_rst_flags #(
    parameter rcc_pkg::rst_evt_t RESET_VAL = rcc_pkg::RSR_RESET_VAL
) (
    input  logic              clk,
    input  logic              rst,
    input  rcc_pkg::rst_evt_t evt,
    input  logic              clr,
    output rcc_pkg::rst_evt_t flags
);
    import rcc_pkg::*;

    rst_evt_t flags_q;
    rst_evt_t flags_nxt;

    // ------------------------------------------------------------------------
    // next state
    // ------------------------------------------------------------------------
    // sticky set where each source only touches its own flag
    // remove-flags holds everything at zero and beats a coincident event
    always_comb begin
        if (clr) begin
            flags_nxt = '0;
        end else begin
            flags_nxt = rst_evt_t'(flags_q | evt);
        end
    end

    // ------------------------------------------------------------------------
    // flag storage
    // ------------------------------------------------------------------------
    // reset loads the documented power-up causes
    always_ff @(posedge clk) begin
        if (rst) begin
            flags_q <= RESET_VAL;
        end else begin
            flags_q <= flags_nxt;
        end
    end

    assign flags = flags_q;

    // ------------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------------
    // rmvf from the register block empties the flags one edge later
    a_clr_empties : assert property (@(posedge clk) disable iff (rst)
        clr |=> flags == rst_evt_t'(0));

endmodule

`default_nettype wire

// ==== rtl/rcc_vdd_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module rcc_vdd_regs (
    input  logic              clk,
    input  logic              rst,
    input  rcc_pkg::reg_wr_t  reg_wr,
    input  rcc_pkg::reg_sel_e rd_sel,
    output logic [31:0]       rd_data,
    input  rcc_pkg::rst_evt_t flags_c1,
    input  rcc_pkg::rst_evt_t flags_c2,
    input  logic              lsi_rdy,
    output logic              rmvf_c1,
    output logic              rmvf_c2,
    output logic              lsion
);
    import rcc_pkg::*;

    // byte lane of each writable bit
    localparam int RMVF_LANE  = RMVF_BIT / 8;
    localparam int LSION_LANE = LSION_BIT / 8;

    rsr_word_u   wr_word;
    rsr_word_u   rsr_c1;
    rsr_word_u   rsr_c2;
    logic [31:0] csr_word;

    // status word from one core's flags
    function automatic rsr_word_u build_rsr(input rst_evt_t flags, input logic rmvf);
        rsr_word_u w;
        w.raw           = '0;
        w.fields.evt_hi = flags[$bits(rst_evt_t)-1:1];
        w.fields.obl    = flags.obl;
        w.fields.rmvf   = rmvf;
        return w;
    endfunction

    // ------------------------------------------------------------------------
    // write side
    // ------------------------------------------------------------------------
    // incoming data seen through the status layout
    assign wr_word.raw = reg_wr.data;

    always_ff @(posedge clk) begin
        if (rst) begin
            rmvf_c1 <= 1'b0;
            rmvf_c2 <= 1'b0;
            lsion   <= 1'b0;
        end else if (reg_wr.valid) begin
            case (reg_wr.sel)
                REG_C1_RSR: begin
                    if (reg_wr.strb[RMVF_LANE]) begin
                        rmvf_c1 <= wr_word.fields.rmvf;
                    end
                end
                REG_C2_RSR: begin
                    if (reg_wr.strb[RMVF_LANE]) begin
                        rmvf_c2 <= wr_word.fields.rmvf;
                    end
                end
                REG_CSR: begin
                    // lsirdy is live status, only lsion stores
                    if (reg_wr.strb[LSION_LANE]) begin
                        lsion <= wr_word.raw[LSION_BIT];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // read side
    // ------------------------------------------------------------------------
    assign rsr_c1 = build_rsr(flags_c1, rmvf_c1);
    assign rsr_c2 = build_rsr(flags_c2, rmvf_c2);

    always_comb begin
        csr_word             = '0;
        csr_word[LSION_BIT]  = lsion;
        csr_word[LSIRDY_BIT] = lsi_rdy;
    end

    // unmapped reads as zero
    always_comb begin
        case (rd_sel)
            REG_CSR:    rd_data = csr_word;
            REG_C1_RSR: rd_data = rsr_c1.raw;
            REG_C2_RSR: rd_data = rsr_c2.raw;
            default:    rd_data = '0;
        endcase
    end

    // slave filters unmapped writes before they get here
    a_wr_mapped : assert property (@(posedge clk) disable iff (rst)
        reg_wr.valid |-> reg_wr.sel != REG_NONE);

endmodule

`default_nettype wire

// ==== rtl/rcc_vdd_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rcc_vdd_top (
    input  logic               clk,
    input  logic               rst,
    input  rcc_pkg::axil_req_t bus_req,
    output rcc_pkg::axil_rsp_t bus_rsp,
    input  rcc_pkg::rst_evt_t  evt,
    input  logic               lsi_rdy,
    output logic               lsion
);
    import rcc_pkg::*;

    reg_wr_t     reg_wr;
    reg_sel_e    rd_sel;
    logic [31:0] rd_data;
    logic        rmvf_c1;
    logic        rmvf_c2;
    rst_evt_t    flags_c1;
    rst_evt_t    flags_c2;

    // ------------------------------------------------------------------------
    // bus front end
    // ------------------------------------------------------------------------
    rcc_axil_slave u_axil_slave (
        .clk     (clk),
        .rst     (rst),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .reg_wr  (reg_wr),
        .rd_sel  (rd_sel),
        .rd_data (rd_data)
    );

    // rmvf, lsion and read mux
    rcc_vdd_regs u_vdd_regs (
        .clk      (clk),
        .rst      (rst),
        .reg_wr   (reg_wr),
        .rd_sel   (rd_sel),
        .rd_data  (rd_data),
        .flags_c1 (flags_c1),
        .flags_c2 (flags_c2),
        .lsi_rdy  (lsi_rdy),
        .rmvf_c1  (rmvf_c1),
        .rmvf_c2  (rmvf_c2),
        .lsion    (lsion)
    );

    // ------------------------------------------------------------------------
    // per-core flag registers, same event bus
    // ------------------------------------------------------------------------
    rcc_rst_flags #(
        .RESET_VAL (RSR_RESET_VAL)
    ) u_flags_c1 (
        .clk   (clk),
        .rst   (rst),
        .evt   (evt),
        .clr   (rmvf_c1),
        .flags (flags_c1)
    );

    rcc_rst_flags #(
        .RESET_VAL (RSR_RESET_VAL)
    ) u_flags_c2 (
        .clk   (clk),
        .rst   (rst),
        .evt   (evt),
        .clr   (rmvf_c2),
        .flags (flags_c2)
    );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the reset-cause recorder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_rcc_vdd -f project.f -o sim_tb
build_status=$?
if [ "$build_status" -ne 0 ]; then
    echo "build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/sim_tb 2>&1)
run_status=$?
printf '%s\n' "$sim_out"
if [ "$run_status" -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Simulation passed"; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

// ==== verif/tb_rcc_vdd.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_rcc_vdd;
    import rcc_pkg::*;

    // about 55 bus transfers at up to 20 cycles each plus event pulses and margin
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int KIND_WRITE     = 0;
    localparam int KIND_READ      = 1;

    logic      clk;
    logic      rst;
    axil_req_t bus_req;
    axil_rsp_t bus_rsp;
    rst_evt_t  evt;
    logic      lsi_rdy;
    logic      lsion;

    // reference model state
    rst_evt_t m_flags [2];
    logic [1:0] m_rmvf;
    logic     m_lsion;

    int          cycles;
    int          bp_max;

    // results waiting for the compare process
    int         kind_q [$];
    string      name_q [$];
    rsr_word_u  exp_word_q [$];
    rsr_word_u  act_word_q [$];
    logic [1:0] exp_resp_q [$];
    logic [1:0] act_resp_q [$];
    int         c_kind;
    string      c_name;
    rsr_word_u  c_exp_w;
    rsr_word_u  c_act_w;
    logic [1:0] c_exp_r;
    logic [1:0] c_act_r;

    rcc_vdd_top u_rcc_vdd_top (
        .clk     (clk),
        .rst     (rst),
        .bus_req (bus_req),
        .bus_rsp (bus_rsp),
        .evt     (evt),
        .lsi_rdy (lsi_rdy),
        .lsion   (lsion)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------
    task automatic check_word(input string name, input rsr_word_u exp, input rsr_word_u act);
        if (exp.raw !== act.raw) begin
            $display("** Error: %s expected %h actual %h", name, exp.raw, act.raw);
            $display("Simulation failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (exp !== act) begin
            $display("** Error: %s expected %b actual %b", name, exp, act);
            $display("Simulation failed");
            $fatal(1, "response mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("** Error: %s expected %b actual %b", name, exp, act);
            $display("Simulation failed");
            $fatal(1, "bit mismatch");
        end
    endtask

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    function automatic logic addr_mapped(input logic [AXI_ADDR_W-1:0] addr);
        return (addr == CSR_ADDR) || (addr == C1_RSR_ADDR) || (addr == C2_RSR_ADDR);
    endfunction

    function automatic rsr_word_u expected_word(input logic [AXI_ADDR_W-1:0] addr);
        rsr_word_u w;
        rst_evt_t  f;
        int        core;
        w.raw = '0;
        if (addr == CSR_ADDR) begin
            w.raw[LSION_BIT]  = m_lsion;
            w.raw[LSIRDY_BIT] = lsi_rdy;
        end else if (addr == C1_RSR_ADDR || addr == C2_RSR_ADDR) begin
            core = (addr == C1_RSR_ADDR) ? 0 : 1;
            f    = m_flags[core];
            w.fields.evt_hi = {f.lpwr2, f.lpwr1, f.wwdg2, f.wwdg1, f.iwdg2, f.iwdg1,
                               f.sft2, f.sft1, f.por, f.pin, f.bor, f.d2, f.d1};
            w.fields.obl    = f.obl;
            w.fields.rmvf   = m_rmvf[core];
        end
        return w;
    endfunction

    // rmvf sits in byte lane 2 and lsion in lane 0
    task automatic model_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        int core;
        if (addr == CSR_ADDR && strb[LSION_BIT/8]) begin
            m_lsion = data[LSION_BIT];
        end
        if ((addr == C1_RSR_ADDR || addr == C2_RSR_ADDR) && strb[RMVF_BIT/8]) begin
            core         = (addr == C1_RSR_ADDR) ? 0 : 1;
            m_rmvf[core] = data[RMVF_BIT];
            if (data[RMVF_BIT]) begin
                m_flags[core] = '0;
            end
        end
    endtask

    // remove-flags beats a coincident event
    task automatic model_event(input rst_evt_t e);
        for (int core = 0; core < 2; core++) begin
            if (m_rmvf[core]) begin
                m_flags[core] = '0;
            end else begin
                m_flags[core] = m_flags[core] | e;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // stimulus helpers
    // ------------------------------------------------------------------------
    function automatic int stall_cycles();
        return (bp_max == 0) ? 0 : int'($urandom_range(bp_max, 0));
    endfunction

    // sparse random pattern that is never empty
    function automatic rst_evt_t random_event();
        logic [31:0] r;
        r = $urandom() & $urandom();
        if (r[13:0] == 14'h0) begin
            r[0] = 1'b1;
        end
        return r[13:0];
    endfunction

    task automatic record_result(input int kind, input string name, input rsr_word_u exp_w,
                                 input rsr_word_u act_w, input logic [1:0] exp_r,
                                 input logic [1:0] act_r);
        kind_q.push_back(kind);
        name_q.push_back(name);
        exp_word_q.push_back(exp_w);
        act_word_q.push_back(act_w);
        exp_resp_q.push_back(exp_r);
        act_resp_q.push_back(act_r);
    endtask

    task automatic pulse_event(input rst_evt_t e);
        @(posedge clk);
        evt <= e;
        @(posedge clk);
        evt <= '0;
        // dut samples the pulse at this edge
        model_event(e);
    endtask

    task automatic axil_write(input string name, input logic [AXI_ADDR_W-1:0] addr,
                              input logic [31:0] data, input logic [3:0] strb);
        int         hold;
        logic [1:0] resp;
        rsr_word_u  none;
        none.raw = '0;
        @(posedge clk);
        bus_req.awvalid <= 1'b1;
        bus_req.awaddr  <= addr;
        bus_req.wvalid  <= 1'b1;
        bus_req.wdata   <= data;
        bus_req.wstrb   <= strb;
        @(negedge clk);
        while (!bus_rsp.awready) @(negedge clk);
        check_bit({name, " wready"}, 1'b1, bus_rsp.wready);
        // accept edge
        @(posedge clk);
        bus_req.awvalid <= 1'b0;
        bus_req.wvalid  <= 1'b0;
        model_write(addr, data, strb);
        @(negedge clk);
        while (!bus_rsp.bvalid) @(negedge clk);
        resp = bus_rsp.bresp;
        hold = stall_cycles();
        repeat (hold) begin
            @(negedge clk);
            check_bit({name, " bvalid held"}, 1'b1, bus_rsp.bvalid);
            check_resp({name, " bresp stable"}, resp, bus_rsp.bresp);
        end
        @(posedge clk);
        bus_req.bready <= 1'b1;
        @(posedge clk);
        bus_req.bready <= 1'b0;
        record_result(KIND_WRITE, name, none, none,
                      addr_mapped(addr) ? RESP_OKAY : RESP_SLVERR, resp);
    endtask

    task automatic axil_read(input string name, input logic [AXI_ADDR_W-1:0] addr);
        int         hold;
        rsr_word_u  exp_w;
        rsr_word_u  act_w;
        logic [1:0] resp;
        @(posedge clk);
        bus_req.arvalid <= 1'b1;
        bus_req.araddr  <= addr;
        @(negedge clk);
        while (!bus_rsp.arready) @(negedge clk);
        @(posedge clk);
        bus_req.arvalid <= 1'b0;
        exp_w = expected_word(addr);
        @(negedge clk);
        while (!bus_rsp.rvalid) @(negedge clk);
        act_w.raw = bus_rsp.rdata;
        resp      = bus_rsp.rresp;
        hold = stall_cycles();
        repeat (hold) begin
            @(negedge clk);
            check_bit({name, " rvalid held"}, 1'b1, bus_rsp.rvalid);
            check_word({name, " rdata stable"}, act_w, bus_rsp.rdata);
            check_resp({name, " rresp stable"}, resp, bus_rsp.rresp);
        end
        @(posedge clk);
        bus_req.rready <= 1'b1;
        @(posedge clk);
        bus_req.rready <= 1'b0;
        record_result(KIND_READ, name, exp_w, act_w,
                      addr_mapped(addr) ? RESP_OKAY : RESP_SLVERR, resp);
    endtask

    task automatic read_all(input string name);
        axil_read({name, " c1"}, C1_RSR_ADDR);
        axil_read({name, " c2"}, C2_RSR_ADDR);
        axil_read({name, " csr"}, CSR_ADDR);
    endtask

    // ------------------------------------------------------------------------
    // compare process
    // ------------------------------------------------------------------------
    always @(negedge clk) begin
        while (kind_q.size() > 0) begin
            c_kind  = kind_q.pop_front();
            c_name  = name_q.pop_front();
            c_exp_w = exp_word_q.pop_front();
            c_act_w = act_word_q.pop_front();
            c_exp_r = exp_resp_q.pop_front();
            c_act_r = act_resp_q.pop_front();
            if (c_kind == KIND_READ) begin
                check_word(c_name, c_exp_w, c_act_w);
            end
            check_resp({c_name, " resp"}, c_exp_r, c_act_r);
        end
    end

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin
        logic [AXI_ADDR_W-1:0] addr;
        logic [AXI_ADDR_W-1:0] other;
        int                    op;
        void'($urandom(23));
        cycles     = 0;
        bp_max     = 0;
        bus_req    = '0;
        evt        = '0;
        lsi_rdy    = 1'b1;
        rst        = 1'b1;
        m_flags[0] = RSR_RESET_VAL;
        m_flags[1] = RSR_RESET_VAL;
        m_rmvf     = 2'b00;
        m_lsion    = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // power-up values
        read_all("reset");

        // sticky flags from random pulses
        repeat (6) begin
            pulse_event(random_event());
            @(posedge clk);
        end
        read_all("events");

        // remove-flags on each core in turn
        for (int core = 0; core < 2; core++) begin
            addr  = (core == 0) ? C1_RSR_ADDR : C2_RSR_ADDR;
            other = (core == 0) ? C2_RSR_ADDR : C1_RSR_ADDR;
            axil_write("rmvf set", addr, 32'h1 << RMVF_BIT, 4'hf);
            axil_read("rmvf cleared", addr);
            axil_read("rmvf other core", other);
            pulse_event(random_event());
            axil_read("rmvf held clear", addr);
            axil_write("rmvf release", addr, 32'h0, 4'hf);
            pulse_event(random_event());
            pulse_event(random_event());
            axil_read("rmvf new events", addr);
            axil_read("rmvf new events other", other);
        end

        // lsion, lane strobes and live lsirdy
        axil_write("lsion on", CSR_ADDR, 32'h1, 4'hf);
        @(negedge clk);
        check_bit("lsion port on", m_lsion, lsion);
        axil_read("lsion readback", CSR_ADDR);
        axil_write("lsion lane off", CSR_ADDR, 32'h0, 4'he);
        @(negedge clk);
        check_bit("lsion port kept", m_lsion, lsion);
        axil_read("lsion kept readback", CSR_ADDR);
        @(posedge clk);
        lsi_rdy <= 1'b0;
        axil_read("lsirdy low", CSR_ADDR);
        check_bit("lsion port after lsirdy", m_lsion, lsion);

        // unmapped offset
        axil_write("unmapped write", 12'h200, 32'hffff_ffff, 4'hf);
        axil_read("unmapped read", 12'h200);
        read_all("after unmapped");

        // random traffic under response back-pressure
        bp_max = 10;
        repeat (20) begin
            op = int'($urandom_range(2, 0));
            case ($urandom_range(2, 0))
                0:       addr = CSR_ADDR;
                1:       addr = C1_RSR_ADDR;
                default: addr = C2_RSR_ADDR;
            endcase
            if (op == 0) begin
                pulse_event(random_event());
            end else if (op == 1) begin
                axil_write("stall write", addr, $urandom(), 4'($urandom()));
                @(negedge clk);
                check_bit("stall lsion port", m_lsion, lsion);
            end else begin
                axil_read("stall read", addr);
            end
        end
        read_all("final");

        repeat (2) @(negedge clk);
        if (kind_q.size() == 0) begin
            $display("Simulation passed");
            $finish;
        end else begin
            $display("results were left unchecked at the end of the run");
            $display("Simulation failed");
            $fatal(1, "unchecked results");
        end
    end

endmodule

`default_nettype wire
